//--- bench/bus_tasks.svh
// Needs clk, the DUT inputs and the error counters of tb_peri_bus in scope, one request at a time
`ifndef BUS_TASKS_SVH
`define BUS_TASKS_SVH

// Longest wait for data_ready before a read counts as lost
localparam int READ_WAIT_MAX = 4;

// Expected readback of the input pins, GPIO offset 0x04 or byte offset 0x1
function automatic logic [DATA_W-1:0] pin_readback(input logic [ADDR_W-1:0] addr,
                                                   input logic [PIN_W-1:0]  pins);
    logic is_byte;
    is_byte = addr[ADDR_W-1];
    if (is_byte && addr[3:0] == 4'h1) begin
        return {24'h0, pins};
    end else if (!is_byte && addr[9:6] == GPIO_SLOT && addr[5:0] == GPIO_IN_OFS) begin
        return {24'h0, pins};
    end
    return '0;
endfunction

// Write is acknowledged in the same cycle and lands at the closing edge
task automatic bus_write(input logic [ADDR_W-1:0] addr, input logic [1:0] acc,
                         input logic [DATA_W-1:0] data);
    @(posedge clk);
    i_addr    <= addr;
    i_data    <= data;
    i_write_n <= acc;
    @(negedge clk);
    if (!o_data_ready) begin
        $display("Write to address 0x%03h was not acknowledged by data_ready", addr);
        handshake_errors++;
    end
    @(posedge clk);
    i_write_n <= ACC_NONE;
endtask

// Read holds the request until data_ready, then checks the data through the hold
task automatic bus_read(input logic [ADDR_W-1:0] addr, input logic [1:0] acc,
                        input logic [DATA_W-1:0] exp);
    int waited;
    waited = 0;
    @(posedge clk);
    i_addr   <= addr;
    i_read_n <= acc;
    @(negedge clk);
    waited = 1;
    while (!o_data_ready && waited < READ_WAIT_MAX) begin
        @(negedge clk);
        waited++;
    end
    if (!o_data_ready) begin
        $display("Read of address 0x%03h got no data_ready within %0d cycles", addr, waited);
        handshake_errors++;
    end else begin
        if (waited != 2) begin
            $display("Read of address 0x%03h took %0d cycles instead of 1", addr, waited - 1);
            handshake_errors++;
        end
        if (o_data !== exp) begin
            $display("ERR o_data addr 0x%03h got 0x%08h exp 0x%08h", addr, o_data, exp);
            value_errors++;
        end
        repeat (2) begin
            // Address moves to the other view, so only the hold keeps o_data
            @(posedge clk);
            i_addr <= {~addr[ADDR_W-1], addr[ADDR_W-2:0]};
            @(negedge clk);
            if (o_data !== exp) begin
                $display("ERR o_data hold addr 0x%03h got 0x%08h exp 0x%08h",
                         addr, o_data, exp);
                value_errors++;
            end
        end
    end
    @(posedge clk);
    i_read_n        <= ACC_NONE;
    i_read_complete <= 1'b1;
    @(posedge clk);
    i_read_complete <= 1'b0;
endtask

`endif

//--- bench/tb_peri_bus.sv
// Runs peri_bus_top with default parameters, two word peripherals from slot 4 and two byte slots
`timescale 1ns/1ps
`default_nettype none

module tb_peri_bus import peri_pkg::*;;

    localparam logic [31:0] SEED = 32'h2dc50d06;

    typedef enum logic [2:0] {
        OP_WRITE,
        OP_READ,
        OP_READ_UI,
        OP_PINS,
        OP_IRQS
    } op_t;

    typedef struct {
        op_t               op;
        logic [ADDR_W-1:0] addr;
        logic [1:0]        acc;
        logic [DATA_W-1:0] wdata;
        logic [DATA_W-1:0] expected;
    } step_t;

    logic              clk;
    logic              rst_n;
    logic [PIN_W-1:0]  i_ui_in;
    logic [PIN_W-1:0]  o_uo_out;
    logic [ADDR_W-1:0] i_addr;
    logic [DATA_W-1:0] i_data;
    logic [1:0]        i_write_n;
    logic [1:0]        i_read_n;
    logic [DATA_W-1:0] o_data;
    logic              o_data_ready;
    logic              i_read_complete;
    logic [15:2]       o_user_interrupts;

    logic [PIN_W-1:0]  ui_val;
    step_t             steps[$];
    int                value_errors = 0;
    int                handshake_errors = 0;
    int                cycle_count = 0;
    int                cycle_limit = 0;

    `include "bus_tasks.svh"

    peri_bus_top uut (
        .clk               (clk),
        .rst_n             (rst_n),
        .i_ui_in           (i_ui_in),
        .o_uo_out          (o_uo_out),
        .i_addr            (i_addr),
        .i_data            (i_data),
        .i_write_n         (i_write_n),
        .i_read_n          (i_read_n),
        .o_data            (o_data),
        .o_data_ready      (o_data_ready),
        .i_read_complete   (i_read_complete),
        .o_user_interrupts (o_user_interrupts)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_limit > 0 && cycle_count > cycle_limit) begin
            $display("Timeout: run did not finish within %0d cycles", cycle_limit);
            $display("*** FAILED ***");
            $finish;
        end
    end

    function automatic logic [ADDR_W-1:0] word_addr(input logic [3:0] slot,
                                                    input logic [5:0] offset);
        return {1'b0, slot, offset};
    endfunction

    function automatic logic [ADDR_W-1:0] byte_addr(input logic [3:0] slot,
                                                    input logic [3:0] offset);
        return {1'b1, 2'b00, slot, offset};
    endfunction

    task automatic push_step(input op_t op, input logic [ADDR_W-1:0] addr, input logic [1:0] acc,
                             input logic [DATA_W-1:0] wdata, input logic [DATA_W-1:0] expected);
        step_t s;
        s.op       = op;
        s.addr     = addr;
        s.acc      = acc;
        s.wdata    = wdata;
        s.expected = expected;
        steps.push_back(s);
    endtask

    task automatic check_pins(input logic [PIN_W-1:0] exp);
        @(negedge clk);
        if (o_uo_out !== exp) begin
            $display("ERR o_uo_out got 0x%02h exp 0x%02h", o_uo_out, exp);
            value_errors++;
        end
    endtask

    task automatic check_irqs(input logic [15:2] exp);
        @(negedge clk);
        if (o_user_interrupts !== exp) begin
            $display("ERR o_user_interrupts got 0x%04h exp 0x%04h",
                     {o_user_interrupts, 2'b00}, {exp, 2'b00});
            value_errors++;
        end
    endtask

    task automatic build_table();
        // Reset state, GPIO output and input readback
        push_step(OP_PINS,    '0,                       ACC_NONE, 32'h0, 32'h0);
        push_step(OP_IRQS,    '0,                       ACC_NONE, 32'h0, 32'h0);
        push_step(OP_WRITE,   word_addr(GPIO_SLOT, GPIO_OUT_OFS), ACC_BYTE, 32'hA5, 32'h0);
        push_step(OP_PINS,    '0,                       ACC_NONE, 32'h0, 32'hA5);
        push_step(OP_READ,    word_addr(GPIO_SLOT, GPIO_OUT_OFS), ACC_WORD, 32'h0, 32'hA5);
        push_step(OP_READ_UI, word_addr(GPIO_SLOT, GPIO_IN_OFS),  ACC_WORD, 32'h0, 32'h0);
        // Function selects start at GPIO
        push_step(OP_READ,    word_addr(GPIO_SLOT, 6'h20), ACC_WORD, 32'h0, 32'h1);
        push_step(OP_READ,    word_addr(GPIO_SLOT, 6'h3C), ACC_WORD, 32'h0, 32'h1);
        push_step(OP_WRITE,   word_addr(4'd4, 6'h00),      ACC_WORD, 32'hC3, 32'h0);
        push_step(OP_WRITE,   byte_addr(4'd0, 4'h0),       ACC_BYTE, 32'h96, 32'h0);
        // Pins 0..3 from word slot 4, pins 4..7 from byte slot 0
        for (int p = 0; p < PIN_W; p++) begin
            push_step(OP_WRITE, word_addr(GPIO_SLOT, GPIO_SEL_BASE + 6'(4 * p)), ACC_WORD,
                      (p < 4) ? 32'h04 : 32'h10, 32'h0);
        end
        push_step(OP_PINS,    '0,                          ACC_NONE, 32'h0, 32'h93);
        push_step(OP_READ,    word_addr(GPIO_SLOT, 6'h24), ACC_WORD, 32'h0, 32'h04);
        push_step(OP_READ,    word_addr(GPIO_SLOT, 6'h30), ACC_WORD, 32'h0, 32'h10);
        // Oversized select keeps 5 bits and names empty byte slot 15
        push_step(OP_WRITE,   word_addr(GPIO_SLOT, 6'h3C), ACC_WORD, 32'h3F, 32'h0);
        push_step(OP_READ,    word_addr(GPIO_SLOT, 6'h3C), ACC_WORD, 32'h0, 32'h1F);
        push_step(OP_PINS,    '0,                          ACC_NONE, 32'h0, 32'h13);
        // Sized writes into register A of slot 4
        push_step(OP_WRITE,   word_addr(4'd4, 6'h00), ACC_WORD, 32'h11223344, 32'h0);
        push_step(OP_WRITE,   word_addr(4'd4, 6'h00), ACC_BYTE, 32'hEEEEEEFF, 32'h0);
        push_step(OP_READ,    word_addr(4'd4, 6'h00), ACC_WORD, 32'h0, 32'h112233FF);
        push_step(OP_WRITE,   word_addr(4'd4, 6'h00), ACC_HALF, 32'h9999ABCD, 32'h0);
        push_step(OP_READ,    word_addr(4'd4, 6'h00), ACC_WORD, 32'h0, 32'h1122ABCD);
        push_step(OP_PINS,    '0,                     ACC_NONE, 32'h0, 32'h1D);
        // Interrupt of slot 5 is bit 5
        push_step(OP_WRITE,   word_addr(4'd5, 6'h04), ACC_WORD, 32'h12345678, 32'h0);
        push_step(OP_IRQS,    '0,                     ACC_NONE, 32'h0, 32'h20);
        push_step(OP_READ,    word_addr(4'd5, 6'h08), ACC_WORD, 32'h0, 32'h1);
        push_step(OP_READ,    word_addr(4'd5, 6'h04), ACC_WORD, 32'h0, 32'h12345678);
        push_step(OP_WRITE,   word_addr(4'd5, 6'h08), ACC_WORD, 32'h0, 32'h0);
        push_step(OP_IRQS,    '0,                     ACC_NONE, 32'h0, 32'h0);
        push_step(OP_READ,    word_addr(4'd5, 6'h08), ACC_WORD, 32'h0, 32'h0);
        // Byte slot 0 load, toggle and readback
        push_step(OP_WRITE,   byte_addr(4'd0, 4'h0), ACC_BYTE, 32'h0F, 32'h0);
        push_step(OP_WRITE,   byte_addr(4'd0, 4'h2), ACC_BYTE, 32'h3C, 32'h0);
        push_step(OP_READ,    byte_addr(4'd0, 4'h0), ACC_BYTE, 32'h0, 32'h33);
        push_step(OP_READ_UI, byte_addr(4'd0, 4'h1), ACC_BYTE, 32'h0, 32'h0);
        push_step(OP_READ,    byte_addr(4'd0, 4'h0), ACC_WORD, 32'h0, 32'h33);
        push_step(OP_PINS,    '0,                    ACC_NONE, 32'h0, 32'h3D);
        // Empty slots
        push_step(OP_READ,    word_addr(4'd2, 6'h00), ACC_WORD, 32'h0, 32'h0);
        push_step(OP_READ,    word_addr(4'd3, 6'h00), ACC_WORD, 32'h0, 32'h0);
        push_step(OP_READ,    word_addr(4'd6, 6'h00), ACC_WORD, 32'h0, 32'h0);
        push_step(OP_READ,    byte_addr(4'd7, 4'h0),  ACC_WORD, 32'h0, 32'h0);
    endtask

    initial begin
        void'($urandom(SEED));
        ui_val = 8'($urandom);
        build_table();
        cycle_limit = steps.size() * 8 + 50;

        rst_n           <= 1'b0;
        i_ui_in         <= ui_val;
        i_addr          <= '0;
        i_data          <= '0;
        i_write_n       <= ACC_NONE;
        i_read_n        <= ACC_NONE;
        i_read_complete <= 1'b0;
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;

        for (int n = 0; n < steps.size(); n++) begin
            case (steps[n].op)
                OP_WRITE:   bus_write(steps[n].addr, steps[n].acc, steps[n].wdata);
                OP_READ:    bus_read(steps[n].addr, steps[n].acc, steps[n].expected);
                OP_READ_UI: bus_read(steps[n].addr, steps[n].acc,
                                     pin_readback(steps[n].addr, ui_val));
                OP_PINS:    check_pins(steps[n].expected[PIN_W-1:0]);
                default:    check_irqs(steps[n].expected[15:2]);
            endcase
        end

        @(posedge clk);
        $display("Errors: %0d value, %0d handshake", value_errors, handshake_errors);
        if (value_errors + handshake_errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- logic/gpio_ctrl.sv
// Function selects reset to the GPIO slot, unmapped offsets read as zero and ignore writes
`timescale 1ns/1ps
`default_nettype none

module gpio_ctrl import peri_pkg::*; (
    input  wire                    clk,
    input  wire                    rst_n,
    input  wire                    i_write,
    input  wire  [5:0]             i_offset,
    input  wire  [7:0]             i_data,
    input  wire  [PIN_W-1:0]       i_ui_in,
    output logic [PIN_W-1:0]       o_gpio_out,
    output logic [FUNC_SEL_W-1:0]  o_func_sel [PIN_W],
    output logic [DATA_W-1:0]      o_rdata
);

    logic       sel_hit;
    logic [2:0] sel_idx;

    // Selects live on word boundaries from 0x20 to 0x3C
    assign sel_hit = ((i_offset & 6'b100011) == GPIO_SEL_BASE);
    assign sel_idx = i_offset[4:2];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            o_gpio_out <= '0;
            for (int i = 0; i < PIN_W; i++) begin
                o_func_sel[i] <= {1'b0, GPIO_SLOT};
            end
        end else if (i_write) begin
            if (i_offset == GPIO_OUT_OFS) begin
                o_gpio_out <= i_data;
            end
            if (sel_hit) begin
                o_func_sel[sel_idx] <= i_data[FUNC_SEL_W-1:0];
            end
        end
    end

    always_comb begin
        if (i_offset == GPIO_OUT_OFS) begin
            o_rdata = DATA_W'(o_gpio_out);
        end else if (i_offset == GPIO_IN_OFS) begin
            o_rdata = DATA_W'(i_ui_in);
        end else if (sel_hit) begin
            o_rdata = DATA_W'(o_func_sel[sel_idx]);
        end else begin
            o_rdata = '0;
        end
    end

endmodule

`default_nettype wire

//--- logic/out_pin_mux.sv
// Combinational, a select naming an empty slot drives the pin low
`timescale 1ns/1ps
`default_nettype none

module out_pin_mux import peri_pkg::*; (
    input  wire  [FUNC_SEL_W-1:0]  i_func_sel [PIN_W],
    input  wire  [PIN_W-1:0]       i_user_out [NUM_SLOTS],
    input  wire  [PIN_W-1:0]       i_byte_out [NUM_SLOTS],
    output logic [PIN_W-1:0]       o_uo_out
);

    logic [SLOT_W-1:0] slot [PIN_W];

    always_comb begin
        for (int i = 0; i < PIN_W; i++) begin
            slot[i] = i_func_sel[i][SLOT_W-1:0];
            // Top select bit picks the byte slots
            if (i_func_sel[i][FUNC_SEL_W-1]) begin
                o_uo_out[i] = i_byte_out[slot[i]][i];
            end else begin
                o_uo_out[i] = i_user_out[slot[i]][i];
            end
        end
    end

endmodule

`default_nettype wire

//--- logic/peri_addr_decode.sv
// Combinational only, word peripherals occupy consecutive slots from FIRST_WORD_SLOT upward
`timescale 1ns/1ps
`default_nettype none

module peri_addr_decode import peri_pkg::*; #(
    parameter int NUM_WORD_PERI = 2,
    parameter int NUM_BYTE_PERI = 2
) (
    input  wire  peri_addr_t   i_addr,
    input  wire  [1:0]         i_write_n,
    input  wire  [1:0]         i_read_n_peri,
    output logic               o_gpio_write,
    input  wire  [DATA_W-1:0]  i_gpio_data,
    output logic [1:0]         o_word_write_n [NUM_WORD_PERI],
    output logic [1:0]         o_word_read_n  [NUM_WORD_PERI],
    input  wire  [DATA_W-1:0]  i_word_data    [NUM_WORD_PERI],
    input  wire                i_word_ready   [NUM_WORD_PERI],
    output logic               o_byte_write   [NUM_BYTE_PERI],
    input  wire  [7:0]         i_byte_data    [NUM_BYTE_PERI],
    output logic [DATA_W-1:0]  o_peri_data,
    output logic               o_peri_ready
);

    logic              is_byte;
    logic [SLOT_W-1:0] word_slot;
    logic [SLOT_W-1:0] byte_slot;
    logic              wr_req;

    assign is_byte   = i_addr.word.byte_peri;
    assign word_slot = i_addr.word.slot;
    assign byte_slot = i_addr.bytes.slot;
    assign wr_req    = (i_write_n != ACC_NONE);

    always_comb begin
        // Empty slots read as zero and are always ready
        o_peri_data  = '0;
        o_peri_ready = 1'b1;
        o_gpio_write = 1'b0;
        for (int i = 0; i < NUM_WORD_PERI; i++) begin
            o_word_write_n[i] = ACC_NONE;
            o_word_read_n[i]  = ACC_NONE;
        end
        for (int i = 0; i < NUM_BYTE_PERI; i++) begin
            o_byte_write[i] = 1'b0;
        end

        if (is_byte) begin
            // Byte slots only return the low byte
            for (int i = 0; i < NUM_BYTE_PERI; i++) begin
                if (byte_slot == SLOT_W'(i)) begin
                    o_byte_write[i] = wr_req;
                    o_peri_data     = DATA_W'(i_byte_data[i]);
                end
            end
        end else if (word_slot == GPIO_SLOT) begin
            o_gpio_write = wr_req;
            o_peri_data  = i_gpio_data;
        end else begin
            for (int i = 0; i < NUM_WORD_PERI; i++) begin
                if (word_slot == SLOT_W'(FIRST_WORD_SLOT + i)) begin
                    o_word_write_n[i] = i_write_n;
                    o_word_read_n[i]  = i_read_n_peri;
                    o_peri_data       = i_word_data[i];
                    o_peri_ready      = i_word_ready[i];
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- logic/peri_bus_top.sv
// NUM_WORD_PERI must stay within 1..12 and NUM_BYTE_PERI within 1..16, other slots read as empty
`timescale 1ns/1ps
`default_nettype none

module peri_bus_top import peri_pkg::*; #(
    parameter int NUM_WORD_PERI = 2,
    parameter int NUM_BYTE_PERI = 2
) (
    input  wire                clk,
    input  wire                rst_n,
    input  wire  [PIN_W-1:0]   i_ui_in,
    output logic [PIN_W-1:0]   o_uo_out,
    input  wire  [ADDR_W-1:0]  i_addr,
    input  wire  [DATA_W-1:0]  i_data,
    input  wire  [1:0]         i_write_n,
    input  wire  [1:0]         i_read_n,
    output logic [DATA_W-1:0]  o_data,
    output logic               o_data_ready,
    input  wire                i_read_complete,
    output logic [15:2]        o_user_interrupts
);

    peri_addr_t addr;

    logic [1:0]            read_n_peri;
    logic [DATA_W-1:0]     peri_data;
    logic                  peri_ready;

    logic                  gpio_write;
    logic [DATA_W-1:0]     gpio_rdata;
    logic [PIN_W-1:0]      gpio_out;
    logic [FUNC_SEL_W-1:0] func_sel [PIN_W];

    logic [1:0]            word_write_n [NUM_WORD_PERI];
    logic [1:0]            word_read_n  [NUM_WORD_PERI];
    logic [DATA_W-1:0]     word_data    [NUM_WORD_PERI];
    logic                  word_ready   [NUM_WORD_PERI];
    logic [PIN_W-1:0]      word_uo      [NUM_WORD_PERI];
    logic                  word_irq     [NUM_WORD_PERI];

    logic                  byte_write   [NUM_BYTE_PERI];
    logic [7:0]            byte_data    [NUM_BYTE_PERI];
    logic [PIN_W-1:0]      byte_uo      [NUM_BYTE_PERI];

    // Output bytes per slot for the pin mux
    logic [PIN_W-1:0]      user_out [NUM_SLOTS];
    logic [PIN_W-1:0]      byte_out [NUM_SLOTS];

    assign addr = i_addr;

    read_data_buffer u_rd_buf (
        .clk             (clk),
        .rst_n           (rst_n),
        .i_read_n        (i_read_n),
        .i_write_n       (i_write_n),
        .i_read_complete (i_read_complete),
        .i_peri_data     (peri_data),
        .i_peri_ready    (peri_ready),
        .o_read_n_peri   (read_n_peri),
        .o_data          (o_data),
        .o_data_ready    (o_data_ready)
    );

    peri_addr_decode #(
        .NUM_WORD_PERI (NUM_WORD_PERI),
        .NUM_BYTE_PERI (NUM_BYTE_PERI)
    ) u_decode (
        .i_addr         (addr),
        .i_write_n      (i_write_n),
        .i_read_n_peri  (read_n_peri),
        .o_gpio_write   (gpio_write),
        .i_gpio_data    (gpio_rdata),
        .o_word_write_n (word_write_n),
        .o_word_read_n  (word_read_n),
        .i_word_data    (word_data),
        .i_word_ready   (word_ready),
        .o_byte_write   (byte_write),
        .i_byte_data    (byte_data),
        .o_peri_data    (peri_data),
        .o_peri_ready   (peri_ready)
    );

    gpio_ctrl u_gpio (
        .clk        (clk),
        .rst_n      (rst_n),
        .i_write    (gpio_write),
        .i_offset   (addr.word.offset),
        .i_data     (i_data[7:0]),
        .i_ui_in    (i_ui_in),
        .o_gpio_out (gpio_out),
        .o_func_sel (func_sel),
        .o_rdata    (gpio_rdata)
    );

    out_pin_mux u_pin_mux (
        .i_func_sel (func_sel),
        .i_user_out (user_out),
        .i_byte_out (byte_out),
        .o_uo_out   (o_uo_out)
    );

    for (genvar g = 0; g < NUM_WORD_PERI; g++) begin : g_word
        user_word_regs u_word (
            .clk         (clk),
            .rst_n       (rst_n),
            .i_offset    (addr.word.offset),
            .i_data      (i_data),
            .i_write_n   (word_write_n[g]),
            .i_read_n    (word_read_n[g]),
            .o_rdata     (word_data[g]),
            .o_ready     (word_ready[g]),
            .o_uo_out    (word_uo[g]),
            .o_interrupt (word_irq[g])
        );
    end

    for (genvar g = 0; g < NUM_BYTE_PERI; g++) begin : g_byte
        user_byte_reg u_byte (
            .clk      (clk),
            .rst_n    (rst_n),
            .i_offset (addr.bytes.offset),
            .i_write  (byte_write[g]),
            .i_data   (i_data[7:0]),
            .i_ui_in  (i_ui_in),
            .o_rdata  (byte_data[g]),
            .o_uo_out (byte_uo[g])
        );
    end

    // Empty slots drive zero on pins and interrupts
    always_comb begin
        for (int s = 0; s < NUM_SLOTS; s++) begin
            user_out[s] = '0;
            byte_out[s] = '0;
        end
        o_user_interrupts = '0;
        user_out[GPIO_SLOT] = gpio_out;
        for (int i = 0; i < NUM_WORD_PERI; i++) begin
            user_out[FIRST_WORD_SLOT + i]          = word_uo[i];
            o_user_interrupts[FIRST_WORD_SLOT + i] = word_irq[i];
        end
        for (int i = 0; i < NUM_BYTE_PERI; i++) begin
            byte_out[i] = byte_uo[i];
        end
    end

endmodule

`default_nettype wire

//--- logic/peri_pkg.sv
// Bus constants assume one core master with 11-bit byte addresses and 16 slots of each kind
`default_nettype none

package peri_pkg;

    localparam int ADDR_W     = 11;
    localparam int DATA_W     = 32;
    localparam int PIN_W      = 8;
    localparam int NUM_SLOTS  = 16;
    localparam int SLOT_W     = 4;
    localparam int FUNC_SEL_W = 5;

    // Request codes shared by read and write lines
    localparam logic [1:0] ACC_NONE = 2'b11;
    localparam logic [1:0] ACC_BYTE = 2'b00;
    localparam logic [1:0] ACC_HALF = 2'b01;
    localparam logic [1:0] ACC_WORD = 2'b10;

    localparam logic [SLOT_W-1:0] GPIO_SLOT       = 4'd1;
    localparam logic [SLOT_W-1:0] FIRST_WORD_SLOT = 4'd4;

    // GPIO register map, select i sits at GPIO_SEL_BASE + 4i
    localparam logic [5:0] GPIO_OUT_OFS  = 6'h00;
    localparam logic [5:0] GPIO_IN_OFS   = 6'h04;
    localparam logic [5:0] GPIO_SEL_BASE = 6'h20;

    typedef struct packed {
        logic              byte_peri;
        logic [SLOT_W-1:0] slot;
        logic [5:0]        offset;
    } word_view_t;

    typedef struct packed {
        logic              byte_peri;
        logic [1:0]        unused;
        logic [SLOT_W-1:0] slot;
        logic [3:0]        offset;
    } byte_view_t;

    // Bit 10 tells which view applies
    typedef union packed {
        word_view_t word;
        byte_view_t bytes;
    } peri_addr_t;

endpackage

`default_nettype wire

//--- logic/read_data_buffer.sv
// Assumes one read in flight and a core that holds the read request until data_ready
`timescale 1ns/1ps
`default_nettype none

module read_data_buffer import peri_pkg::*; (
    input  wire                clk,
    input  wire                rst_n,
    input  wire  [1:0]         i_read_n,
    input  wire  [1:0]         i_write_n,
    input  wire                i_read_complete,
    input  wire  [DATA_W-1:0]  i_peri_data,
    input  wire                i_peri_ready,
    output logic [1:0]         o_read_n_peri,
    output logic [DATA_W-1:0]  o_data,
    output logic               o_data_ready
);

    logic read_req;
    logic capture;
    logic hold;
    logic ready_r;

    assign read_req = (i_read_n != ACC_NONE);
    assign capture  = !hold && i_peri_ready && read_req;

    // No second read reaches the peripheral while the result is pending
    assign o_read_n_peri = i_read_n | {2{ready_r}};

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            hold    <= 1'b0;
            ready_r <= 1'b0;
        end else begin
            if (i_read_complete) begin
                hold <= 1'b0;
            end
            if (capture) begin
                hold <= 1'b1;
            end
            ready_r <= read_req && i_peri_ready;
        end
    end

    always_ff @(posedge clk) begin
        if (capture) begin
            o_data <= i_peri_data;
        end
    end

    // Writes complete in the cycle they are presented
    assign o_data_ready = ready_r || (i_write_n != ACC_NONE);

endmodule

`default_nettype wire

//--- logic/user_byte_reg.sv
// Example byte peripheral with output byte at 0x0, pin readback at 0x1 and toggle at 0x2
`timescale 1ns/1ps
`default_nettype none

module user_byte_reg import peri_pkg::*; (
    input  wire               clk,
    input  wire               rst_n,
    input  wire  [3:0]        i_offset,
    input  wire               i_write,
    input  wire  [7:0]        i_data,
    input  wire  [PIN_W-1:0]  i_ui_in,
    output logic [7:0]        o_rdata,
    output logic [PIN_W-1:0]  o_uo_out
);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            o_uo_out <= '0;
        end else if (i_write) begin
            case (i_offset)
                4'h0: o_uo_out <= i_data;
                // Flip only the bits written as one
                4'h2: o_uo_out <= o_uo_out ^ i_data;
                default: ;
            endcase
        end
    end

    always_comb begin
        case (i_offset)
            4'h0:    o_rdata = o_uo_out;
            4'h1:    o_rdata = i_ui_in;
            default: o_rdata = '0;
        endcase
    end

endmodule

`default_nettype wire

//--- logic/user_word_regs.sv
// Example peripheral that is always ready, registers A at 0x0 and B at 0x4, interrupt flag at 0x8
`timescale 1ns/1ps
`default_nettype none

module user_word_regs import peri_pkg::*; (
    input  wire                clk,
    input  wire                rst_n,
    input  wire  [5:0]         i_offset,
    input  wire  [DATA_W-1:0]  i_data,
    input  wire  [1:0]         i_write_n,
    input  wire  [1:0]         i_read_n,
    output logic [DATA_W-1:0]  o_rdata,
    output logic               o_ready,
    output logic [PIN_W-1:0]   o_uo_out,
    output logic               o_interrupt
);

    localparam logic [5:0] OFS_A   = 6'h00;
    localparam logic [5:0] OFS_B   = 6'h04;
    localparam logic [5:0] OFS_IRQ = 6'h08;

    logic [DATA_W-1:0] reg_a;
    logic [DATA_W-1:0] reg_b;

    // Sized write keeps the upper bits of the old value
    function automatic logic [DATA_W-1:0] merge(input logic [DATA_W-1:0] old_val,
                                                input logic [DATA_W-1:0] new_val,
                                                input logic [1:0]        acc);
        case (acc)
            ACC_BYTE: merge = {old_val[DATA_W-1:8], new_val[7:0]};
            ACC_HALF: merge = {old_val[DATA_W-1:16], new_val[15:0]};
            ACC_WORD: merge = new_val;
            default:  merge = old_val;
        endcase
    endfunction

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            reg_a       <= '0;
            reg_b       <= '0;
            o_interrupt <= 1'b0;
        end else if (i_write_n != ACC_NONE) begin
            case (i_offset)
                OFS_A: reg_a <= merge(reg_a, i_data, i_write_n);
                OFS_B: begin
                    reg_b       <= merge(reg_b, i_data, i_write_n);
                    o_interrupt <= 1'b1;
                end
                OFS_IRQ: o_interrupt <= 1'b0;
                default: ;
            endcase
        end
    end

    always_comb begin
        case (i_offset)
            OFS_A:   o_rdata = reg_a;
            OFS_B:   o_rdata = reg_b;
            OFS_IRQ: o_rdata = DATA_W'(o_interrupt);
            default: o_rdata = '0;
        endcase
    end

    assign o_ready  = (i_read_n != ACC_NONE);
    assign o_uo_out = reg_a[PIN_W-1:0];

endmodule

`default_nettype wire

//--- run_sim.sh
#!/bin/sh
# Builds the testbench with Verilator, runs it and checks the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f src.f --top-module tb_peri_bus -o tb_peri_bus
./obj_dir/tb_peri_bus > sim.log 2>&1
cat sim.log

if grep -qF '*** FAILED ***' sim.log; then
    echo "Simulation reported a failure"
    exit 1
fi
if ! grep -qF '*** PASSED ***' sim.log; then
    echo "Simulation ended without a result line"
    exit 1
fi
echo "Simulation finished without errors"

//--- src.f
+incdir+bench
logic/peri_pkg.sv
logic/user_word_regs.sv
logic/user_byte_reg.sv
logic/gpio_ctrl.sv
logic/out_pin_mux.sv
logic/read_data_buffer.sv
logic/peri_addr_decode.sv
logic/peri_bus_top.sv
bench/tb_peri_bus.sv
